// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = status_tb
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+include
logic/status_pkg.sv
logic/soft_error_counter.sv
logic/ext_trigger_counter.sv
logic/status_reg_block.sv
logic/status_read_port.sv
logic/rider_status_top.sv
verification/status_tb.sv

// ==== include/firmware_version.svh ====
`ifndef FIRMWARE_VERSION_SVH
`define FIRMWARE_VERSION_SVH

// Firmware revision reported in status word 00
// Bump MAJOR_REV on register map changes
`define MAJOR_REV 8'd3
`define MINOR_REV 8'd1
`define PATCH_REV 8'd0

`endif

// ==== logic/ext_trigger_counter.sv ====
`timescale 1ns/1ps

module ext_trigger_counter import status_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // Front panel trigger, one cycle per trigger
  input  logic             ext_trig,
  // Level, high while triggers are accepted
  input  logic             accept_en,
  // End of one readout
  input  logic             readout_done,
  output ext_trig_counts_t counts
);

  err_count_t raw_count;
  err_count_t accepted_count;
  trig_num_t  pulse_trig_num;
  trig_num_t  trigs_last_readout;
  trig_num_t  since_readout;
  trig_num_t  since_next;
  logic       accepted_trig;

  assign accepted_trig = ext_trig & accept_en;

  // Running count since the last readout, this cycle's trigger included
  always_comb begin
    since_next = since_readout;
    if (accepted_trig) begin
      since_next = since_readout + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      raw_count          <= '0;
      accepted_count     <= '0;
      pulse_trig_num     <= '0;
      trigs_last_readout <= '0;
      since_readout      <= '0;
    end else begin
      // Every trigger, accepted or not
      if (ext_trig) begin
        raw_count <= raw_count + 1'b1;
      end
      if (accepted_trig) begin
        accepted_count <= accepted_count + 1'b1;
        // 24-bit trigger number wraps like the TTC one
        pulse_trig_num <= pulse_trig_num + 1'b1;
      end
      // Snapshot then restart
      if (readout_done) begin
        trigs_last_readout <= since_next;
        since_readout      <= '0;
      end else begin
        since_readout <= since_next;
      end
    end
  end

  assign counts = '{
    raw_count:          raw_count,
    accepted_count:     accepted_count,
    pulse_trig_num:     pulse_trig_num,
    trigs_last_readout: trigs_last_readout
  };

endmodule

// ==== logic/rider_status_top.sv ====
`timescale 1ns/1ps

module rider_status_top import status_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // Slow status levels from the rest of the firmware
  input  fpga_status_t                fpga,
  input  hard_error_t                 hard_err,
  input  clock_status_t               clocks,
  input  link_status_t                link,
  input  fsm_states_t                 fsm,
  input  acq_status_t                 acq,
  input  trig_status_t                trig,
  input  xadc_status_t                xadc,
  input  burst_count_t [NUM_CHAN-1:0] stored_bursts,
  // Soft error thresholds
  input  err_count_t                  thres_data_corrupt,
  input  err_count_t                  thres_unknown_ttc,
  input  err_count_t                  thres_ddr3_overflow,
  // Soft error pulses
  input  logic                        data_corrupt_pulse,
  input  logic                        unknown_ttc_pulse,
  input  logic                        ddr3_overflow_pulse,
  input  logic                        err_clear,
  // Front panel trigger
  input  logic                        ext_trig,
  input  logic                        accept_en,
  input  logic                        readout_done,
  // Bus read port
  input  logic                        rd_stb,
  input  reg_addr_t                   rd_addr,
  output status_word_t                rd_data,
  output logic                        rd_ack,
  // Not in the map, routed out for the board logic
  output logic                        ddr3_overflow_error
);

  soft_error_t                 data_corrupt_counts;
  soft_error_t                 unknown_ttc_counts;
  soft_error_t                 ddr3_overflow_counts;
  logic                        data_corrupt_error;
  logic                        unknown_ttc_error;
  ext_trig_counts_t            ext_trig_counts;
  status_word_t [NUM_REGS-1:0] status_words;

  // Checksum mismatches
  soft_error_counter i_data_corrupt_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .err_pulse  (data_corrupt_pulse),
    .err_clear  (err_clear),
    .threshold  (thres_data_corrupt),
    .counts     (data_corrupt_counts),
    .hard_error (data_corrupt_error)
  );

  // Unknown TTC broadcast commands
  soft_error_counter i_unknown_ttc_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .err_pulse  (unknown_ttc_pulse),
    .err_clear  (err_clear),
    .threshold  (thres_unknown_ttc),
    .counts     (unknown_ttc_counts),
    .hard_error (unknown_ttc_error)
  );

  soft_error_counter i_ddr3_overflow_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .err_pulse  (ddr3_overflow_pulse),
    .err_clear  (err_clear),
    .threshold  (thres_ddr3_overflow),
    .counts     (ddr3_overflow_counts),
    .hard_error (ddr3_overflow_error)
  );

  ext_trigger_counter i_ext_trig_cnt (
    .clk          (clk),
    .rst_n        (rst_n),
    .ext_trig     (ext_trig),
    .accept_en    (accept_en),
    .readout_done (readout_done),
    .counts       (ext_trig_counts)
  );

  status_reg_block i_status_regs (
    .clk                (clk),
    .rst_n              (rst_n),
    .fpga               (fpga),
    .hard_err           (hard_err),
    .data_corrupt_error (data_corrupt_error),
    .unknown_ttc_error  (unknown_ttc_error),
    .clocks             (clocks),
    .link               (link),
    .fsm                (fsm),
    .acq                (acq),
    .trig               (trig),
    .xadc               (xadc),
    .stored_bursts      (stored_bursts),
    .data_corrupt       (data_corrupt_counts),
    .unknown_ttc        (unknown_ttc_counts),
    .ddr3_overflow      (ddr3_overflow_counts),
    .ext_trig           (ext_trig_counts),
    .status_words       (status_words)
  );

  // three cycles input to rd_data, counters included
  status_read_port i_read_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .status_words (status_words),
    .rd_stb       (rd_stb),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .rd_ack       (rd_ack)
  );

endmodule

// ==== logic/soft_error_counter.sv ====
`timescale 1ns/1ps

module soft_error_counter import status_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // One cycle per error occurrence
  input  logic        err_pulse,
  input  logic        err_clear,
  // Zero disables the hard error
  input  err_count_t  threshold,
  output soft_error_t counts,
  output logic        hard_error
);

  err_count_t count_q;
  err_count_t count_next;
  logic       limit_hit;

  // Next count with saturation at all ones
  always_comb begin
    count_next = count_q;
    if (err_pulse && (count_q != '1)) begin
      count_next = count_q + 1'b1;
    end
  end

  // Compare includes this cycle's pulse
  assign limit_hit = (threshold != '0) && (count_next >= threshold);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q    <= '0;
      hard_error <= 1'b0;
    end else if (err_clear) begin
      // Clear wins over a pulse in the same cycle
      count_q    <= '0;
      hard_error <= 1'b0;
    end else begin
      count_q <= count_next;
      // Sticky until the next clear
      if (limit_hit) begin
        hard_error <= 1'b1;
      end
    end
  end

  // Threshold echoed so the map can show it beside the count
  assign counts = '{count: count_q, threshold: threshold};

endmodule

// ==== logic/status_pkg.sv ====
package status_pkg;

  // Fixed by the register map
  localparam int NUM_CHAN = 5;
  localparam int NUM_REGS = 32;

  typedef logic [31:0] status_word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] err_count_t;
  typedef logic [23:0] trig_num_t;
  typedef logic [22:0] burst_count_t;
  // One bit per digitizer channel
  typedef logic [NUM_CHAN-1:0] chan_mask_t;

  typedef struct packed {
    logic is_golden;
    logic prog_chan_done;
    logic async_mode;
    logic cbuf_mode;
  } fpga_status_t;

  // Hard errors detected outside this subsystem
  typedef struct packed {
    logic       trig_type_from_cm;
    logic       trig_type_from_tt;
    logic       trig_num_from_cm;
    logic       trig_num_from_tt;
    logic       trig_rate;
    logic       pll_unlock;
    chan_mask_t chan_error_sn;
    chan_mask_t chan_error_rc;
    logic       ddr3_almost_full;
  } hard_error_t;

  // External clock select and synthesizer status pins
  typedef struct packed {
    logic daq_clk_sel;
    logic daq_clk_en;
    logic adcclk_clkin0_stat;
    logic adcclk_clkin1_stat;
    logic adcclk_stat_ld;
    logic adcclk_stat;
  } clock_status_t;

  typedef struct packed {
    logic       daq_almost_full;
    logic       daq_ready;
    logic [3:0] tts_state;
    logic [5:0] ttc_chan_b_info;
    logic       ttc_ready;
  } link_status_t;

  // One-hot state codes of the readout FSMs
  typedef struct packed {
    logic [34:0] cm_state;
    logic [3:0]  ttr_state;
    logic [4:0]  ptr_state;
    logic [3:0]  cac_state;
    logic [3:0]  caca_state;
    logic [3:0]  cacc_state;
    logic [6:0]  tp_state;
  } fsm_states_t;

  typedef struct packed {
    chan_mask_t acq_readout_pause;
    chan_mask_t fill_type;
    chan_mask_t chan_en;
    chan_mask_t acq_dones;
    logic       endianness_sel;
    logic       accept_pulse_triggers;
    logic       ttc_accept_pulse_triggers;
    logic       ipb_accept_pulse_triggers;
  } acq_status_t;

  // Latest TTC trigger as seen by the trigger processor
  typedef struct packed {
    logic        trig_fifo_full;
    logic        pulse_fifo_full;
    logic        acq_fifo_full;
    logic [2:0]  trig_settings;
    logic [31:0] trig_delay;
    trig_num_t   trig_num;
    logic [43:0] trig_timestamp;
  } trig_status_t;

  typedef struct packed {
    logic [11:0] i2c_temp;
    logic [15:0] temp;
    logic [15:0] vccint;
    logic [15:0] vccaux;
    logic [15:0] vccbram;
    logic        over_temp;
    logic        alarm_temp;
    logic        alarm_vccint;
    logic        alarm_vccaux;
    logic        alarm_vccbram;
  } xadc_status_t;

  typedef struct packed {
    err_count_t count;
    err_count_t threshold;
  } soft_error_t;

  // Front panel trigger statistics
  typedef struct packed {
    err_count_t raw_count;
    err_count_t accepted_count;
    trig_num_t  pulse_trig_num;
    trig_num_t  trigs_last_readout;
  } ext_trig_counts_t;

  // Status word indices
  localparam reg_addr_t REG_VERSION             = 5'd0;
  localparam reg_addr_t REG_ERROR               = 5'd1;
  localparam reg_addr_t REG_CLK_TEMP            = 5'd2;
  localparam reg_addr_t REG_CLK_SYNTH           = 5'd3;
  localparam reg_addr_t REG_DAQ_LINK            = 5'd4;
  localparam reg_addr_t REG_TTC_TTS             = 5'd5;
  localparam reg_addr_t REG_FSM_STATE0          = 5'd6;
  localparam reg_addr_t REG_FSM_STATE1          = 5'd7;
  localparam reg_addr_t REG_ACQ                 = 5'd8;
  localparam reg_addr_t REG_TRIG_INFO           = 5'd9;
  localparam reg_addr_t REG_TRIG_DELAY          = 5'd10;
  localparam reg_addr_t REG_TRIG_NUM            = 5'd11;
  localparam reg_addr_t REG_TRIG_TS_LSB         = 5'd12;
  localparam reg_addr_t REG_TRIG_TS_MSB         = 5'd13;
  localparam reg_addr_t REG_PULSE_TRIG_NUM      = 5'd14;
  localparam reg_addr_t REG_DATA_CORRUPT_THRES  = 5'd15;
  localparam reg_addr_t REG_DATA_CORRUPT_COUNT  = 5'd16;
  localparam reg_addr_t REG_UNKNOWN_TTC_THRES   = 5'd17;
  localparam reg_addr_t REG_UNKNOWN_TTC_COUNT   = 5'd18;
  localparam reg_addr_t REG_DDR3_OVERFLOW_THRES = 5'd19;
  localparam reg_addr_t REG_DDR3_OVERFLOW_COUNT = 5'd20;
  // Channel n burst count sits at REG_BURSTS_CHAN0 + n
  localparam reg_addr_t REG_BURSTS_CHAN0        = 5'd21;
  localparam reg_addr_t REG_XADC_TEMP_VCCINT    = 5'd26;
  localparam reg_addr_t REG_XADC_VCCAUX_VCCBRAM = 5'd27;
  localparam reg_addr_t REG_XADC_ALARMS         = 5'd28;
  localparam reg_addr_t REG_EXT_RAW_COUNT       = 5'd29;
  localparam reg_addr_t REG_EXT_LAST_READOUT    = 5'd30;
  localparam reg_addr_t REG_EXT_ACCEPTED_COUNT  = 5'd31;

endpackage

// ==== logic/status_read_port.sv ====
`timescale 1ns/1ps

module status_read_port import status_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // Registered bank from status_reg_block
  input  status_word_t [NUM_REGS-1:0] status_words,
  // Bus side, one strobe per read
  input  logic                        rd_stb,
  input  reg_addr_t                   rd_addr,
  output status_word_t                rd_data,
  output logic                        rd_ack
);

  // One read per cycle, no back-pressure
  // A new strobe may arrive while the previous ack is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
      rd_ack  <= 1'b0;
    end else begin
      // Ack is the strobe delayed by one cycle
      rd_ack <= rd_stb;
      // Data only moves on a strobe and holds otherwise
      if (rd_stb) begin
        rd_data <= status_words[rd_addr];
      end
    end
  end

endmodule

// ==== logic/status_reg_block.sv ====
`timescale 1ns/1ps
`include "firmware_version.svh"

module status_reg_block import status_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fpga_status_t                     fpga,
  input  hard_error_t                      hard_err,
  // Sticky flags from the soft error counters
  input  logic                             data_corrupt_error,
  input  logic                             unknown_ttc_error,
  input  clock_status_t                    clocks,
  input  link_status_t                     link,
  input  fsm_states_t                      fsm,
  input  acq_status_t                      acq,
  input  trig_status_t                     trig,
  input  xadc_status_t                     xadc,
  input  burst_count_t [NUM_CHAN-1:0]      stored_bursts,
  input  soft_error_t                      data_corrupt,
  input  soft_error_t                      unknown_ttc,
  input  soft_error_t                      ddr3_overflow,
  input  ext_trig_counts_t                 ext_trig,
  output status_word_t [NUM_REGS-1:0]      status_words
);

  status_word_t [NUM_REGS-1:0] words_d;

  always_comb begin
    // Unused bits and words read as zero
    words_d = '0;

    // Mode bits on top and the revision in the low 24 bits
    words_d[REG_VERSION] = {fpga.is_golden, fpga.prog_chan_done, fpga.async_mode,
                            fpga.cbuf_mode, 4'd0, `MAJOR_REV, `MINOR_REV, `PATCH_REV};

    // Error summary
    words_d[REG_ERROR] = {13'd0, hard_err.ddr3_almost_full, hard_err.chan_error_rc,
                          hard_err.chan_error_sn, hard_err.trig_type_from_cm,
                          hard_err.trig_type_from_tt, hard_err.trig_num_from_cm,
                          hard_err.trig_num_from_tt, data_corrupt_error,
                          hard_err.trig_rate, unknown_ttc_error, hard_err.pll_unlock};

    // Board temperature shares a word with the clock select
    words_d[REG_CLK_TEMP] = {xadc.i2c_temp, 18'd0, clocks.daq_clk_sel, clocks.daq_clk_en};

    words_d[REG_CLK_SYNTH] = {28'd0, clocks.adcclk_clkin1_stat, clocks.adcclk_clkin0_stat,
                              clocks.adcclk_stat_ld, clocks.adcclk_stat};

    words_d[REG_DAQ_LINK] = {30'd0, link.daq_almost_full, link.daq_ready};

    words_d[REG_TTC_TTS] = {21'd0, link.tts_state, link.ttc_chan_b_info, link.ttc_ready};

    // Command manager state needs more than one word
    words_d[REG_FSM_STATE0] = fsm.cm_state[31:0];
    words_d[REG_FSM_STATE1] = {fsm.cm_state[34:32], 1'd0, fsm.cacc_state, fsm.ptr_state[4],
                               fsm.tp_state, fsm.caca_state, fsm.cac_state,
                               fsm.ptr_state[3:0], fsm.ttr_state};

    words_d[REG_ACQ] = {8'd0, acq.ipb_accept_pulse_triggers, acq.ttc_accept_pulse_triggers,
                        acq.accept_pulse_triggers, acq.acq_dones, acq.endianness_sel,
                        acq.acq_readout_pause, acq.fill_type, acq.chan_en};

    // TTC trigger words
    words_d[REG_TRIG_INFO]   = {26'd0, trig.pulse_fifo_full, trig.trig_settings,
                                trig.acq_fifo_full, trig.trig_fifo_full};
    words_d[REG_TRIG_DELAY]  = trig.trig_delay;
    words_d[REG_TRIG_NUM]    = {8'd0, trig.trig_num};
    words_d[REG_TRIG_TS_LSB] = trig.trig_timestamp[31:0];
    words_d[REG_TRIG_TS_MSB] = {20'd0, trig.trig_timestamp[43:32]};

    words_d[REG_PULSE_TRIG_NUM] = {8'd0, ext_trig.pulse_trig_num};

    // Threshold and count pairs
    words_d[REG_DATA_CORRUPT_THRES]  = data_corrupt.threshold;
    words_d[REG_DATA_CORRUPT_COUNT]  = data_corrupt.count;
    words_d[REG_UNKNOWN_TTC_THRES]   = unknown_ttc.threshold;
    words_d[REG_UNKNOWN_TTC_COUNT]   = unknown_ttc.count;
    words_d[REG_DDR3_OVERFLOW_THRES] = ddr3_overflow.threshold;
    words_d[REG_DDR3_OVERFLOW_COUNT] = ddr3_overflow.count;

    // One word per channel
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      words_d[REG_BURSTS_CHAN0 + ch] = {9'd0, stored_bursts[ch]};
    end

    words_d[REG_XADC_TEMP_VCCINT]    = {xadc.vccint, xadc.temp};
    words_d[REG_XADC_VCCAUX_VCCBRAM] = {xadc.vccbram, xadc.vccaux};
    words_d[REG_XADC_ALARMS]         = {27'd0, xadc.alarm_vccbram, xadc.alarm_vccaux,
                                        xadc.alarm_vccint, xadc.alarm_temp, xadc.over_temp};

    // Front panel trigger statistics
    words_d[REG_EXT_RAW_COUNT]      = ext_trig.raw_count;
    words_d[REG_EXT_LAST_READOUT]   = {8'd0, ext_trig.trigs_last_readout};
    words_d[REG_EXT_ACCEPTED_COUNT] = ext_trig.accepted_count;
  end

  // Whole bank updates on one edge, so a read never mixes two cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_words <= '0;
    end else begin
      status_words <= words_d;
    end
  end

endmodule

// ==== verification/status_tb.sv ====
`timescale 1ns/1ps
`include "firmware_version.svh"

module status_tb import status_pkg::*; ();

  localparam int ACK_TIMEOUT = 8;

  logic clk = 1'b0;
  logic rst_n;
  fpga_status_t fpga;
  hard_error_t hard_err;
  clock_status_t clocks;
  link_status_t link;
  fsm_states_t fsm;
  acq_status_t acq;
  trig_status_t trig;
  xadc_status_t xadc;
  burst_count_t [NUM_CHAN-1:0] stored_bursts;
  err_count_t thres_data_corrupt;
  err_count_t thres_unknown_ttc;
  err_count_t thres_ddr3_overflow;
  logic data_corrupt_pulse;
  logic unknown_ttc_pulse;
  logic ddr3_overflow_pulse;
  logic err_clear;
  logic ext_trig;
  logic accept_en;
  logic readout_done;
  logic rd_stb;
  reg_addr_t rd_addr;
  status_word_t rd_data;
  logic rd_ack;
  logic ddr3_overflow_error;

  // Reference model of the counters
  err_count_t dc_count, ut_count, dd_count;
  logic dc_flag, ut_flag, dd_flag;
  err_count_t raw_model, accepted_model;
  trig_num_t pulse_num_model, since_model, last_model;

  // Expected word of the read in flight
  reg_addr_t exp_addr;
  status_word_t exp_data;

  int mismatch_count = 0;
  int ack_count = 0;
  int timeout_count = 0;

  rider_status_top i_dut (.*);

  always #10 clk = ~clk;

  // Register map built field by field
  function automatic status_word_t expected_word(input reg_addr_t addr);
    status_word_t w;
    w = '0;
    case (addr)
      REG_VERSION: begin
        w[31:28] = {fpga.is_golden, fpga.prog_chan_done, fpga.async_mode, fpga.cbuf_mode};
        w[23:16] = `MAJOR_REV;
        w[15:8]  = `MINOR_REV;
        w[7:0]   = `PATCH_REV;
      end
      REG_ERROR: begin
        w[0]     = hard_err.pll_unlock;
        w[1]     = ut_flag;
        w[2]     = hard_err.trig_rate;
        w[3]     = dc_flag;
        w[4]     = hard_err.trig_num_from_tt;
        w[5]     = hard_err.trig_num_from_cm;
        w[6]     = hard_err.trig_type_from_tt;
        w[7]     = hard_err.trig_type_from_cm;
        w[12:8]  = hard_err.chan_error_sn;
        w[17:13] = hard_err.chan_error_rc;
        w[18]    = hard_err.ddr3_almost_full;
      end
      REG_CLK_TEMP: begin
        w[31:20] = xadc.i2c_temp;
        w[1:0]   = {clocks.daq_clk_sel, clocks.daq_clk_en};
      end
      REG_CLK_SYNTH: w[3:0] = {clocks.adcclk_clkin1_stat, clocks.adcclk_clkin0_stat,
                               clocks.adcclk_stat_ld, clocks.adcclk_stat};
      REG_DAQ_LINK: w[1:0] = {link.daq_almost_full, link.daq_ready};
      REG_TTC_TTS: begin
        w[10:7] = link.tts_state;
        w[6:1]  = link.ttc_chan_b_info;
        w[0]    = link.ttc_ready;
      end
      REG_FSM_STATE0: w = fsm.cm_state[31:0];
      REG_FSM_STATE1: begin
        w[31:29] = fsm.cm_state[34:32];
        w[27:24] = fsm.cacc_state;
        w[23]    = fsm.ptr_state[4];
        w[22:16] = fsm.tp_state;
        w[15:12] = fsm.caca_state;
        w[11:8]  = fsm.cac_state;
        w[7:4]   = fsm.ptr_state[3:0];
        w[3:0]   = fsm.ttr_state;
      end
      REG_ACQ: begin
        w[23:21] = {acq.ipb_accept_pulse_triggers, acq.ttc_accept_pulse_triggers,
                    acq.accept_pulse_triggers};
        w[20:16] = acq.acq_dones;
        w[15]    = acq.endianness_sel;
        w[14:10] = acq.acq_readout_pause;
        w[9:5]   = acq.fill_type;
        w[4:0]   = acq.chan_en;
      end
      REG_TRIG_INFO: begin
        w[5]   = trig.pulse_fifo_full;
        w[4:2] = trig.trig_settings;
        w[1:0] = {trig.acq_fifo_full, trig.trig_fifo_full};
      end
      REG_TRIG_DELAY: w = trig.trig_delay;
      REG_TRIG_NUM: w[23:0] = trig.trig_num;
      REG_TRIG_TS_LSB: w = trig.trig_timestamp[31:0];
      REG_TRIG_TS_MSB: w[11:0] = trig.trig_timestamp[43:32];
      REG_PULSE_TRIG_NUM: w[23:0] = pulse_num_model;
      REG_DATA_CORRUPT_THRES: w = thres_data_corrupt;
      REG_DATA_CORRUPT_COUNT: w = dc_count;
      REG_UNKNOWN_TTC_THRES: w = thres_unknown_ttc;
      REG_UNKNOWN_TTC_COUNT: w = ut_count;
      REG_DDR3_OVERFLOW_THRES: w = thres_ddr3_overflow;
      REG_DDR3_OVERFLOW_COUNT: w = dd_count;
      REG_XADC_TEMP_VCCINT: w = {xadc.vccint, xadc.temp};
      REG_XADC_VCCAUX_VCCBRAM: w = {xadc.vccbram, xadc.vccaux};
      REG_XADC_ALARMS: w[4:0] = {xadc.alarm_vccbram, xadc.alarm_vccaux, xadc.alarm_vccint,
                                 xadc.alarm_temp, xadc.over_temp};
      REG_EXT_RAW_COUNT: w = raw_model;
      REG_EXT_LAST_READOUT: w[23:0] = last_model;
      REG_EXT_ACCEPTED_COUNT: w = accepted_model;
      // Channel burst words 21 to 25
      default: w[22:0] = stored_bursts[addr - REG_BURSTS_CHAN0];
    endcase
    return w;
  endfunction

  // Capture the expected word with the strobe
  always @(posedge clk) begin
    if (rd_stb) begin
      exp_addr <= rd_addr;
      exp_data <= expected_word(rd_addr);
    end
  end

  ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n) rd_stb |=> rd_ack)
    else begin
      $display("ack error at %0t: rd_ack did not rise one cycle after rd_stb", $time);
      ack_count++;
    end

  no_ack_without_stb: assert property (@(posedge clk) disable iff (!rst_n)
                                       !rd_stb |=> !rd_ack)
    else begin
      $display("ack error at %0t: rd_ack high without a strobe", $time);
      ack_count++;
    end

  data_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
                                       rd_ack |-> (rd_data == exp_data))
    else begin
      $display("mismatch at %0t: register %0d read %h, expected %h",
               $time, $sampled(exp_addr), $sampled(rd_data), $sampled(exp_data));
      mismatch_count++;
    end

  // Read data only moves with an acknowledge
  data_holds_between_reads: assert property (@(posedge clk) disable iff (!rst_n)
                                             !rd_ack |-> $stable(rd_data))
    else begin
      $display("mismatch at %0t: rd_data changed to %h without an acknowledge",
               $time, $sampled(rd_data));
      mismatch_count++;
    end

  // Inputs move 2 ns after the edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic update_soft(input logic pulse, input logic clr, input err_count_t thr,
                             inout err_count_t cnt, inout logic flag);
    if (clr) begin
      cnt  = '0;
      flag = 1'b0;
    end else begin
      if (pulse && (cnt != '1)) begin
        cnt = cnt + 1;
      end
      if ((thr != '0) && (cnt >= thr)) begin
        flag = 1'b1;
      end
    end
  endtask

  // One cycle of pulses with the model stepped alongside
  task automatic drive_cycle(input logic dc, input logic ut, input logic dd, input logic clr,
                             input logic trg, input logic acc, input logic rdone);
    data_corrupt_pulse  = dc;
    unknown_ttc_pulse   = ut;
    ddr3_overflow_pulse = dd;
    err_clear           = clr;
    ext_trig            = trg;
    accept_en           = acc;
    readout_done        = rdone;
    update_soft(dc, clr, thres_data_corrupt, dc_count, dc_flag);
    update_soft(ut, clr, thres_unknown_ttc, ut_count, ut_flag);
    update_soft(dd, clr, thres_ddr3_overflow, dd_count, dd_flag);
    if (trg) begin
      raw_model++;
    end
    if (trg && acc) begin
      accepted_model++;
      pulse_num_model++;
      since_model++;
    end
    if (rdone) begin
      last_model  = since_model;
      since_model = '0;
    end
    step();
  endtask

  // Pulses low and four cycles for the input to reach the bank
  task automatic settle();
    data_corrupt_pulse  = 1'b0;
    unknown_ttc_pulse   = 1'b0;
    ddr3_overflow_pulse = 1'b0;
    err_clear           = 1'b0;
    ext_trig            = 1'b0;
    readout_done        = 1'b0;
    repeat (4) step();
  endtask

  task automatic read_reg(input reg_addr_t addr);
    logic got;
    got     = 1'b0;
    rd_addr = addr;
    rd_stb  = 1'b1;
    step();
    rd_stb = 1'b0;
    for (int t = 0; t < ACK_TIMEOUT && !got; t++) begin
      if (rd_ack) begin
        got = 1'b1;
      end else begin
        step();
      end
    end
    if (!got) begin
      $display("timeout at %0t: no acknowledge arrived for register %0d", $time, addr);
      timeout_count++;
    end
    step();
  endtask

  task automatic read_all();
    for (int a = 0; a < NUM_REGS; a++) begin
      read_reg(reg_addr_t'(a));
    end
  endtask

  // Strobes on consecutive cycles with every ack left to the assertions
  task automatic read_burst(input int n);
    for (int i = 0; i < n; i++) begin
      rd_addr = reg_addr_t'($urandom);
      rd_stb  = 1'b1;
      step();
    end
    rd_stb = 1'b0;
    for (int t = 0; t < ACK_TIMEOUT && rd_ack; t++) begin
      step();
    end
    if (rd_ack) begin
      $display("timeout at %0t: rd_ack stayed high after the burst", $time);
      timeout_count++;
    end
  endtask

  task automatic randomize_status();
    logic [127:0] r;
    r        = {$urandom, $urandom, $urandom, $urandom};
    fpga     = r[3:0];
    hard_err = r[20:4];
    clocks   = r[26:21];
    link     = r[39:27];
    acq      = r[63:40];
    fsm      = r[126:64];
    r        = {$urandom, $urandom, $urandom, $urandom};
    trig     = r[105:0];
    r        = {$urandom, $urandom, $urandom, $urandom};
    xadc     = r[80:0];
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      r                 = {96'd0, $urandom};
      stored_bursts[ch] = r[22:0];
    end
  endtask

  task automatic check_ddr3_flag();
    assert (ddr3_overflow_error == dd_flag)
      else begin
        $display("mismatch at %0t: ddr3_overflow_error is %b, expected %b",
                 $time, ddr3_overflow_error, dd_flag);
        mismatch_count++;
      end
  endtask

  initial begin
    void'($urandom(32'hdc95_3414));
    rst_n = 1'b0;
    {fpga, hard_err, clocks, link, fsm, acq, trig, xadc} = '0;
    stored_bursts = '0;
    {thres_data_corrupt, thres_unknown_ttc, thres_ddr3_overflow} = '0;
    {data_corrupt_pulse, unknown_ttc_pulse, ddr3_overflow_pulse, err_clear} = '0;
    {ext_trig, accept_en, readout_done, rd_stb} = '0;
    rd_addr = '0;
    {dc_count, ut_count, dd_count, raw_model, accepted_model} = '0;
    {dc_flag, ut_flag, dd_flag} = '0;
    {pulse_num_model, since_model, last_model} = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Reset values and the idle map
    assert (!rd_ack && (rd_data == '0))
      else begin
        $display("mismatch at %0t: read port not cleared by reset", $time);
        mismatch_count++;
      end
    settle();
    read_all();

    // Random bundles over the whole map
    repeat (2) begin
      randomize_status();
      settle();
      read_all();
    end

    // Zero unknown TTC threshold never flags
    thres_data_corrupt  = 3 + ($urandom % 4);
    thres_unknown_ttc   = '0;
    thres_ddr3_overflow = 2 + ($urandom % 3);
    settle();
    repeat (12) begin
      drive_cycle(1'($urandom), 1'($urandom), 1'($urandom), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    settle();
    for (int a = REG_ERROR; a <= REG_DDR3_OVERFLOW_COUNT; a++) begin
      read_reg(reg_addr_t'(a));
    end
    check_ddr3_flag();
    // Clear wins over pulses in the same cycle
    drive_cycle(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    settle();
    read_reg(REG_ERROR);
    read_reg(REG_DATA_CORRUPT_COUNT);
    read_reg(REG_UNKNOWN_TTC_COUNT);
    read_reg(REG_DDR3_OVERFLOW_COUNT);
    check_ddr3_flag();

    // Front panel triggers with random accept and readouts
    repeat (80) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'($urandom), 1'($urandom),
                  ($urandom % 6) == 0);
    end
    // Trigger in the readout cycle counts in the snapshot
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
    settle();
    read_reg(REG_PULSE_TRIG_NUM);
    read_reg(REG_EXT_RAW_COUNT);
    read_reg(REG_EXT_LAST_READOUT);
    read_reg(REG_EXT_ACCEPTED_COUNT);

    read_burst(40);
    repeat (2) step();

    $display("errors: mismatch %0d, ack %0d, timeout %0d",
             mismatch_count, ack_count, timeout_count);
    if ((mismatch_count + ack_count + timeout_count) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
